/* Bender.yml */
package:
  name: dac_regmap

sources:
  - dac_regmap_pkg.sv
  - dac_regmap_addr_decode.sv
  - dac_regmap_common.sv
  - dac_regmap_channel.sv
  - dac_regmap_rdata_combine.sv
  - dac_regmap_top.sv
  - target: test
    files:
      - dac_regmap_assertions.sv
      - tb_dac_regmap.sv

/* all.f */
dac_regmap_pkg.sv
dac_regmap_addr_decode.sv
dac_regmap_common.sv
dac_regmap_channel.sv
dac_regmap_rdata_combine.sv
dac_regmap_top.sv
dac_regmap_assertions.sv
tb_dac_regmap.sv

/* dac_regmap_addr_decode.sv */
`timescale 1ns/1ps

module dac_regmap_addr_decode #(
  parameter int num_channels = 2
) (
  input  logic                                     up_clk,
  input  logic                                     up_rstn,
  input  logic                                     up_wreq,
  input  logic [dac_regmap_pkg::up_addr_width-1:0] up_waddr,
  input  logic [dac_regmap_pkg::up_data_width-1:0] up_wdata,
  input  logic                                     up_rreq,
  input  logic [dac_regmap_pkg::up_addr_width-1:0] up_raddr,
  output logic                                     dec_valid,
  output dac_regmap_pkg::up_req_t                  dec_req
);

  import dac_regmap_pkg::*;

  logic [up_addr_width-1:0] addr;
  logic                     hit_common;
  logic                     hit_chan;
  logic                     wr_q;
  logic                     rd_q;
  logic                     sel_common_q;
  logic [7:0]               sel_chan_q;
  logic [5:0]               offset_q;
  logic [up_data_width-1:0] wdata_q;

  // Write wins when both strobes show up together
  assign addr = up_wreq ? up_waddr : up_raddr;

  // Common bank 0x000..0x03F, channels 0x100 + 16*i
  assign hit_common = (addr[10:6] == 5'd0);
  assign hit_chan   = (addr[10:7] == 4'b0010) && (int'(addr[6:4]) < num_channels);

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      dec_valid    <= 1'b0;
      wr_q         <= 1'b0;
      rd_q         <= 1'b0;
      sel_common_q <= 1'b0;
      sel_chan_q   <= '0;
    end else begin
      dec_valid    <= up_wreq | up_rreq;
      wr_q         <= up_wreq;
      rd_q         <= up_rreq & ~up_wreq;
      sel_common_q <= (up_wreq | up_rreq) & hit_common;
      sel_chan_q   <= ((up_wreq | up_rreq) & hit_chan) ? (8'd1 << addr[6:4]) : 8'd0;
    end
  end

  // Register offset within the bank and write data
  always_ff @(posedge up_clk) begin
    offset_q <= hit_common ? addr[5:0] : {2'b00, addr[3:0]};
    wdata_q  <= up_wdata;
  end

  assign dec_req = '{wr: wr_q, rd: rd_q, sel_common: sel_common_q, sel_chan: sel_chan_q,
                     offset: offset_q, wdata: wdata_q};

endmodule

/* dac_regmap_assertions.sv */
`timescale 1ns/1ps

module dac_regmap_assertions #(
  parameter int num_channels = 2
) (
  input logic                                                  up_clk,
  input logic                                                  up_rstn,
  input logic                                                  up_wreq,
  input logic                                                  up_rreq,
  input logic                                                  up_wack,
  input logic                                                  up_rack,
  input logic [dac_regmap_pkg::up_data_width-1:0]              up_rdata,
  input logic                                                  dac_rst,
  input logic                                                  dac_sync,
  input dac_regmap_pkg::dac_chan_cfg_t [num_channels-1:0]      dac_chan_cfg
);

  // Number of assertion failures so far
  int fail_count = 0;

  // ************************************************************
  // Acknowledge latency, fixed at two cycles
  // ************************************************************

  wack_after_wreq: assert property (@(posedge up_clk) disable iff (!up_rstn)
    up_wreq |-> ##2 up_wack)
    else begin $error("write strobe not acknowledged two cycles later"); fail_count++; end

  wack_has_wreq: assert property (@(posedge up_clk) disable iff (!up_rstn)
    up_wack |-> $past(up_wreq, 2))
    else begin $error("write acknowledge without a write strobe two cycles earlier"); fail_count++; end

  rack_after_rreq: assert property (@(posedge up_clk) disable iff (!up_rstn)
    (up_rreq && !up_wreq) |-> ##2 up_rack)
    else begin $error("read strobe not acknowledged two cycles later"); fail_count++; end

  rack_has_rreq: assert property (@(posedge up_clk) disable iff (!up_rstn)
    up_rack |-> $past(up_rreq, 2))
    else begin $error("read acknowledge without a read strobe two cycles earlier"); fail_count++; end

  // Sync request is a single cycle pulse
  sync_single_cycle: assert property (@(posedge up_clk) disable iff (!up_rstn)
    dac_sync |=> !dac_sync)
    else begin $error("dac_sync high for more than one cycle"); fail_count++; end

  // Outputs one cycle after a reset edge
  reset_values: assert property (@(posedge up_clk)
    !up_rstn |=> (!up_wack && !up_rack && !dac_sync && dac_rst &&
                  (up_rdata == '0) && (dac_chan_cfg == '0)))
    else begin $error("outputs not at their reset values"); fail_count++; end

endmodule

/* dac_regmap_channel.sv */
`timescale 1ns/1ps

module dac_regmap_channel (
  input  logic                                     up_clk,
  input  logic                                     up_rstn,
  input  dac_regmap_pkg::up_req_t                  dec_req,
  input  logic                                     chan_sel,
  output dac_regmap_pkg::dac_chan_cfg_t            chan_cfg,
  output logic [dac_regmap_pkg::up_data_width-1:0] bank_rdata
);

  import dac_regmap_pkg::*;

  localparam logic [5:0] off_tone_0  = 6'h00;
  localparam logic [5:0] off_tone_1  = 6'h01;
  localparam logic [5:0] off_pattern = 6'h02;
  localparam logic [5:0] off_control = 6'h03;
  localparam logic [5:0] off_src_sel = 6'h04;

  logic       wr_en;
  logic       rd_en;
  chan_word_u wword;

  assign wr_en = dec_req.wr & chan_sel;
  assign rd_en = dec_req.rd & chan_sel;

  // Incoming data word, decoded per offset below
  assign wword = dec_req.wdata;

  // ************************************************************
  // Register writes
  // ************************************************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      chan_cfg <= '0;
    end else if (wr_en) begin
      case (dec_req.offset)
        off_tone_0: begin
          chan_cfg.dds_init_0 <= wword.dds.init;
          chan_cfg.dds_incr_0 <= wword.dds.incr;
        end
        off_tone_1: begin
          chan_cfg.dds_init_1 <= wword.dds.init;
          chan_cfg.dds_incr_1 <= wword.dds.incr;
        end
        off_pattern: begin
          chan_cfg.pat_data_0 <= wword.pat.pat_data_0;
          chan_cfg.pat_data_1 <= wword.pat.pat_data_1;
        end
        off_control: begin
          chan_cfg.data_sel    <= dec_req.wdata[3:0];
          chan_cfg.mask_enable <= dec_req.wdata[8];
        end
        off_src_sel: begin
          chan_cfg.src_chan_sel <= dec_req.wdata[7:0];
        end
        default: begin
        end
      endcase
    end
  end

  // ************************************************************
  // Read word, same layout as written
  // ************************************************************

  always_comb begin
    chan_word_u rword;
    rword      = '0;
    bank_rdata = '0;
    if (rd_en) begin
      case (dec_req.offset)
        off_tone_0: begin
          rword.dds.init = chan_cfg.dds_init_0;
          rword.dds.incr = chan_cfg.dds_incr_0;
          bank_rdata     = rword;
        end
        off_tone_1: begin
          rword.dds.init = chan_cfg.dds_init_1;
          rword.dds.incr = chan_cfg.dds_incr_1;
          bank_rdata     = rword;
        end
        off_pattern: begin
          rword.pat.pat_data_0 = chan_cfg.pat_data_0;
          rword.pat.pat_data_1 = chan_cfg.pat_data_1;
          bank_rdata           = rword;
        end
        off_control: bank_rdata = {23'd0, chan_cfg.mask_enable, 4'd0, chan_cfg.data_sel};
        off_src_sel: bank_rdata = {24'd0, chan_cfg.src_chan_sel};
        default:     bank_rdata = '0;
      endcase
    end
  end

endmodule

/* dac_regmap_common.sv */
`timescale 1ns/1ps

module dac_regmap_common #(
  parameter int num_channels = 2,
  parameter int core_id      = 0
) (
  input  logic                                     up_clk,
  input  logic                                     up_rstn,
  input  dac_regmap_pkg::up_req_t                  dec_req,
  input  logic                                     dac_underflow,
  input  logic                                     dac_sync_in_status,
  output logic                                     dac_rst,
  output logic                                     dac_sync,
  output logic                                     dac_dds_format,
  output logic [dac_regmap_pkg::up_data_width-1:0] bank_rdata
);

  import dac_regmap_pkg::*;

  localparam logic [5:0] off_version   = 6'h00;
  localparam logic [5:0] off_core_id   = 6'h01;
  localparam logic [5:0] off_scratch   = 6'h02;
  localparam logic [5:0] off_rst_ctrl  = 6'h10;
  localparam logic [5:0] off_sync_ctrl = 6'h11;
  localparam logic [5:0] off_format    = 6'h12;
  localparam logic [5:0] off_status    = 6'h20;
  localparam logic [5:0] off_sync_in   = 6'h21;
  localparam logic [5:0] off_config    = 6'h22;

  logic                     wr_en;
  logic                     rd_en;
  logic [up_data_width-1:0] scratch;
  logic                     rst_release;
  logic                     underflow_sticky;
  logic                     underflow_clr;

  assign wr_en = dec_req.wr & dec_req.sel_common;
  assign rd_en = dec_req.rd & dec_req.sel_common;

  assign underflow_clr = wr_en && (dec_req.offset == off_status) && dec_req.wdata[0];

  // ************************************************************
  // Register writes
  // ************************************************************

  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      scratch          <= '0;
      rst_release      <= 1'b0;
      dac_dds_format   <= 1'b0;
      dac_sync         <= 1'b0;
      underflow_sticky <= 1'b0;
    end else begin
      if (wr_en && (dec_req.offset == off_scratch))  scratch        <= dec_req.wdata;
      if (wr_en && (dec_req.offset == off_rst_ctrl)) rst_release    <= dec_req.wdata[0];
      if (wr_en && (dec_req.offset == off_format))   dac_dds_format <= dec_req.wdata[0];
      // Self clearing, high for one cycle only
      dac_sync <= wr_en && (dec_req.offset == off_sync_ctrl) && dec_req.wdata[0];
      // A new underflow beats a clear in the same cycle
      underflow_sticky <= dac_underflow | (underflow_sticky & ~underflow_clr);
    end
  end

  // DAC stays in reset until software releases it
  assign dac_rst = ~rst_release;

  // ************************************************************
  // Read word
  // ************************************************************

  always_comb begin
    bank_rdata = '0;
    if (rd_en) begin
      case (dec_req.offset)
        off_version:   bank_rdata = dac_regmap_version;
        off_core_id:   bank_rdata = 32'(core_id);
        off_scratch:   bank_rdata = scratch;
        off_rst_ctrl:  bank_rdata = {31'd0, rst_release};
        off_format:    bank_rdata = {31'd0, dac_dds_format};
        off_status:    bank_rdata = {31'd0, underflow_sticky};
        off_sync_in:   bank_rdata = {31'd0, dac_sync_in_status};
        off_config:    bank_rdata = {24'd0, 8'(num_channels)};
        default:       bank_rdata = '0;
      endcase
    end
  end

endmodule

/* dac_regmap_pkg.sv */
package dac_regmap_pkg;

  // ************************************************************
  // Bus geometry
  // ************************************************************

  // Word address on the processor bus
  localparam int up_addr_width = 11;

  // Register width
  localparam int up_data_width = 32;

  // Identity word at common offset 0x00
  localparam logic [up_data_width-1:0] dac_regmap_version = 32'h0001_0261;

  // ************************************************************
  // Decoded request
  // ************************************************************

  // One request after the decode stage. Selects are all zero
  // for an address that hits no bank.
  typedef struct packed {
    logic                     wr;
    logic                     rd;
    logic                     sel_common;
    logic [7:0]               sel_chan;
    logic [5:0]               offset;
    logic [up_data_width-1:0] wdata;
  } up_req_t;

  // ************************************************************
  // Channel data word and channel outputs
  // ************************************************************

  // Tone word view
  typedef struct packed {
    logic [15:0] incr;
    logic [15:0] init;
  } dds_word_t;

  // Pattern word view
  typedef struct packed {
    logic [15:0] pat_data_1;
    logic [15:0] pat_data_0;
  } pat_word_t;

  // Same 32-bit register word, decoded as tone or pattern
  typedef union packed {
    dds_word_t dds;
    pat_word_t pat;
  } chan_word_u;

  // Configuration of one channel as seen by the datapath
  typedef struct packed {
    logic [3:0]  data_sel;
    logic        mask_enable;
    logic [7:0]  src_chan_sel;
    logic [15:0] dds_init_0;
    logic [15:0] dds_incr_0;
    logic [15:0] dds_init_1;
    logic [15:0] dds_incr_1;
    logic [15:0] pat_data_0;
    logic [15:0] pat_data_1;
  } dac_chan_cfg_t;

endpackage

/* dac_regmap_rdata_combine.sv */
`timescale 1ns/1ps

module dac_regmap_rdata_combine #(
  parameter int num_banks = 3
) (
  input  logic                                                    up_clk,
  input  logic                                                    up_rstn,
  input  logic                                                    dec_valid,
  input  dac_regmap_pkg::up_req_t                                 dec_req,
  input  logic [num_banks-1:0][dac_regmap_pkg::up_data_width-1:0] bank_rdata_all,
  output logic                                                    up_wack,
  output logic                                                    up_rack,
  output logic [dac_regmap_pkg::up_data_width-1:0]                up_rdata
);

  import dac_regmap_pkg::*;

  logic [up_data_width-1:0] rdata_or;

  // Unselected banks drive zero, so a plain OR merges them
  always_comb begin
    rdata_or = '0;
    for (int b = 0; b < num_banks; b++) begin
      rdata_or = rdata_or | bank_rdata_all[b];
    end
  end

  // Second pipeline stage, acknowledge two cycles after the strobe
  always_ff @(posedge up_clk) begin
    if (!up_rstn) begin
      up_wack  <= 1'b0;
      up_rack  <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_wack  <= dec_valid & dec_req.wr;
      up_rack  <= dec_valid & dec_req.rd;
      up_rdata <= rdata_or;
    end
  end

endmodule

/* dac_regmap_top.sv */
`timescale 1ns/1ps

module dac_regmap_top #(
  parameter int num_channels = 2,
  parameter int core_id      = 0
) (
  input  logic                                             up_clk,
  input  logic                                             up_rstn,
  input  logic                                             up_wreq,
  input  logic [dac_regmap_pkg::up_addr_width-1:0]         up_waddr,
  input  logic [dac_regmap_pkg::up_data_width-1:0]         up_wdata,
  input  logic                                             up_rreq,
  input  logic [dac_regmap_pkg::up_addr_width-1:0]         up_raddr,
  input  logic                                             dac_underflow,
  input  logic                                             dac_sync_in_status,
  output logic                                             up_wack,
  output logic                                             up_rack,
  output logic [dac_regmap_pkg::up_data_width-1:0]         up_rdata,
  output logic                                             dac_rst,
  output logic                                             dac_sync,
  output logic                                             dac_dds_format,
  output dac_regmap_pkg::dac_chan_cfg_t [num_channels-1:0] dac_chan_cfg
);

  import dac_regmap_pkg::*;

  localparam int num_banks = num_channels + 1;

  logic                                    dec_valid;
  up_req_t                                 dec_req;
  // Bank 0 is the common bank, bank i+1 is channel i
  logic [num_banks-1:0][up_data_width-1:0] bank_rdata;

  dac_regmap_addr_decode #(
    .num_channels (num_channels)
  ) i_addr_decode (
    .up_clk    (up_clk),
    .up_rstn   (up_rstn),
    .up_wreq   (up_wreq),
    .up_waddr  (up_waddr),
    .up_wdata  (up_wdata),
    .up_rreq   (up_rreq),
    .up_raddr  (up_raddr),
    .dec_valid (dec_valid),
    .dec_req   (dec_req)
  );

  dac_regmap_common #(
    .num_channels (num_channels),
    .core_id      (core_id)
  ) i_common (
    .up_clk             (up_clk),
    .up_rstn            (up_rstn),
    .dec_req            (dec_req),
    .dac_underflow      (dac_underflow),
    .dac_sync_in_status (dac_sync_in_status),
    .dac_rst            (dac_rst),
    .dac_sync           (dac_sync),
    .dac_dds_format     (dac_dds_format),
    .bank_rdata         (bank_rdata[0])
  );

  for (genvar i = 0; i < num_channels; i++) begin : g_channel
    dac_regmap_channel i_channel (
      .up_clk     (up_clk),
      .up_rstn    (up_rstn),
      .dec_req    (dec_req),
      .chan_sel   (dec_req.sel_chan[i]),
      .chan_cfg   (dac_chan_cfg[i]),
      .bank_rdata (bank_rdata[i+1])
    );
  end

  dac_regmap_rdata_combine #(
    .num_banks (num_banks)
  ) i_rdata_combine (
    .up_clk         (up_clk),
    .up_rstn        (up_rstn),
    .dec_valid      (dec_valid),
    .dec_req        (dec_req),
    .bank_rdata_all (bank_rdata),
    .up_wack        (up_wack),
    .up_rack        (up_rack),
    .up_rdata       (up_rdata)
  );

endmodule

/* tb_dac_regmap.sv */
`timescale 1ns/1ps

module tb_dac_regmap;

  import dac_regmap_pkg::*;

  localparam int          num_channels = 2;
  localparam int          core_id      = 'h3c;
  localparam int          ack_timeout  = 20;
  localparam logic [31:0] lfsr_taps    = 32'h8020_0003;

  logic                                up_clk;
  logic                                up_rstn;
  logic                                up_wreq;
  logic [up_addr_width-1:0]            up_waddr;
  logic [up_data_width-1:0]            up_wdata;
  logic                                up_rreq;
  logic [up_addr_width-1:0]            up_raddr;
  logic                                dac_underflow;
  logic                                dac_sync_in_status;
  logic                                up_wack;
  logic                                up_rack;
  logic [up_data_width-1:0]            up_rdata;
  logic                                dac_rst;
  logic                                dac_sync;
  logic                                dac_dds_format;
  dac_chan_cfg_t [num_channels-1:0]    dac_chan_cfg;

  int            value_errors   = 0;
  int            timeout_errors = 0;
  int            total_errors;
  logic [31:0]   lfsr_state     = 32'hde7f6b74;
  logic [31:0]   word;
  logic [10:0]   base;
  dac_chan_cfg_t exp_cfg [num_channels];

  dac_regmap_top #(
    .num_channels (num_channels),
    .core_id      (core_id)
  ) DUT (
    .up_clk             (up_clk),
    .up_rstn            (up_rstn),
    .up_wreq            (up_wreq),
    .up_waddr           (up_waddr),
    .up_wdata           (up_wdata),
    .up_rreq            (up_rreq),
    .up_raddr           (up_raddr),
    .dac_underflow      (dac_underflow),
    .dac_sync_in_status (dac_sync_in_status),
    .up_wack            (up_wack),
    .up_rack            (up_rack),
    .up_rdata           (up_rdata),
    .dac_rst            (dac_rst),
    .dac_sync           (dac_sync),
    .dac_dds_format     (dac_dds_format),
    .dac_chan_cfg       (dac_chan_cfg)
  );

  bind dac_regmap_top dac_regmap_assertions #(
    .num_channels (num_channels)
  ) u_assertions (
    .up_clk       (up_clk),
    .up_rstn      (up_rstn),
    .up_wreq      (up_wreq),
    .up_rreq      (up_rreq),
    .up_wack      (up_wack),
    .up_rack      (up_rack),
    .up_rdata     (up_rdata),
    .dac_rst      (dac_rst),
    .dac_sync     (dac_sync),
    .dac_chan_cfg (dac_chan_cfg)
  );

  initial begin
    up_clk = 1'b0;
    forever #20 up_clk = ~up_clk;
  end

  // ************************************************************
  // Helpers
  // ************************************************************

  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    if (state[0]) return (state >> 1) ^ lfsr_taps;
    return state >> 1;
  endfunction

  // One LFSR step per bit
  task automatic random_word(output logic [31:0] value);
    for (int i = 0; i < 32; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value[i]   = lfsr_state[0];
    end
  endtask

  task automatic check_value(input string name, input logic [127:0] expected,
                             input logic [127:0] actual);
    assert (actual === expected)
      else begin
        $display("MISMATCH %s: expected 0x%0h, actual 0x%0h", name, expected, actual);
        value_errors++;
      end
  endtask

  task automatic write_reg(input logic [10:0] addr, input logic [31:0] data);
    int cycles;
    @(negedge up_clk);
    up_wreq  = 1'b1;
    up_waddr = addr;
    up_wdata = data;
    @(negedge up_clk);
    up_wreq = 1'b0;
    cycles  = 0;
    while (!up_wack && cycles < ack_timeout) begin
      @(negedge up_clk);
      cycles++;
    end
    if (!up_wack) begin
      $display("Write to address 0x%0h got no acknowledge within %0d cycles", addr, ack_timeout);
      timeout_errors++;
    end
  endtask

  task automatic read_reg(input logic [10:0] addr, output logic [31:0] data);
    int cycles;
    @(negedge up_clk);
    up_rreq  = 1'b1;
    up_raddr = addr;
    @(negedge up_clk);
    up_rreq = 1'b0;
    cycles  = 0;
    while (!up_rack && cycles < ack_timeout) begin
      @(negedge up_clk);
      cycles++;
    end
    if (!up_rack) begin
      $display("Read of address 0x%0h got no acknowledge within %0d cycles", addr, ack_timeout);
      timeout_errors++;
    end
    data = up_rdata;
  endtask

  task automatic read_check(input string name, input logic [10:0] addr,
                            input logic [31:0] expected);
    logic [31:0] data;
    read_reg(addr, data);
    check_value(name, expected, data);
  endtask

  // ************************************************************
  // Stimulus
  // ************************************************************

  initial begin
    up_rstn            = 1'b0;
    up_wreq            = 1'b0;
    up_waddr           = '0;
    up_wdata           = '0;
    up_rreq            = 1'b0;
    up_raddr           = '0;
    dac_underflow      = 1'b0;
    dac_sync_in_status = 1'b0;
    repeat (8) @(negedge up_clk);
    up_rstn = 1'b1;

    check_value("reset dac_rst", 1, dac_rst);
    check_value("reset dac_sync", 0, dac_sync);
    check_value("reset dac_dds_format", 0, dac_dds_format);
    check_value("reset acknowledges", 0, {up_wack, up_rack});
    check_value("reset chan0 cfg", 0, dac_chan_cfg[0]);
    check_value("reset chan1 cfg", 0, dac_chan_cfg[1]);

    // Identity, scratch and unmapped space
    read_check("version", 11'h000, dac_regmap_version);
    read_check("core_id", 11'h001, core_id);
    read_check("config", 11'h022, num_channels);
    random_word(word);
    write_reg(11'h002, word);
    read_check("scratch", 11'h002, word);
    read_check("unmapped common", 11'h005, 0);
    read_check("top of map", 11'h7ff, 0);

    for (int ch = 0; ch < num_channels; ch++) begin
      base        = 11'h100 + 11'(16 * ch);
      exp_cfg[ch] = '0;
      if (ch == 1) begin
        check_value("chan1 before writes", 0, dac_chan_cfg[1]);
      end
      random_word(word);
      write_reg(base, word);
      exp_cfg[ch].dds_init_0 = word[15:0];
      exp_cfg[ch].dds_incr_0 = word[31:16];
      check_value($sformatf("chan%0d dds_init_0", ch), word[15:0], dac_chan_cfg[ch].dds_init_0);
      check_value($sformatf("chan%0d dds_incr_0", ch), word[31:16], dac_chan_cfg[ch].dds_incr_0);
      read_check($sformatf("chan%0d tone 0", ch), base, word);
      random_word(word);
      write_reg(base + 11'h1, word);
      exp_cfg[ch].dds_init_1 = word[15:0];
      exp_cfg[ch].dds_incr_1 = word[31:16];
      check_value($sformatf("chan%0d dds_init_1", ch), word[15:0], dac_chan_cfg[ch].dds_init_1);
      check_value($sformatf("chan%0d dds_incr_1", ch), word[31:16], dac_chan_cfg[ch].dds_incr_1);
      read_check($sformatf("chan%0d tone 1", ch), base + 11'h1, word);
      random_word(word);
      write_reg(base + 11'h2, word);
      exp_cfg[ch].pat_data_0 = word[15:0];
      exp_cfg[ch].pat_data_1 = word[31:16];
      check_value($sformatf("chan%0d pat_data_0", ch), word[15:0], dac_chan_cfg[ch].pat_data_0);
      check_value($sformatf("chan%0d pat_data_1", ch), word[31:16], dac_chan_cfg[ch].pat_data_1);
      read_check($sformatf("chan%0d pattern", ch), base + 11'h2, word);
      random_word(word);
      write_reg(base + 11'h3, word);
      exp_cfg[ch].data_sel    = word[3:0];
      exp_cfg[ch].mask_enable = word[8];
      check_value($sformatf("chan%0d data_sel", ch), word[3:0], dac_chan_cfg[ch].data_sel);
      check_value($sformatf("chan%0d mask_enable", ch), word[8], dac_chan_cfg[ch].mask_enable);
      read_check($sformatf("chan%0d control", ch), base + 11'h3, word & 32'h0000_010f);
      random_word(word);
      write_reg(base + 11'h4, word);
      exp_cfg[ch].src_chan_sel = word[7:0];
      check_value($sformatf("chan%0d src_chan_sel", ch), word[7:0], dac_chan_cfg[ch].src_chan_sel);
      read_check($sformatf("chan%0d source select", ch), base + 11'h4, word & 32'h0000_00ff);
    end

    // Unused channel space reads zero and ignores writes
    read_check("unused chan0 offset", 11'h105, 0);
    read_check("absent chan2", 11'h120, 0);
    random_word(word);
    write_reg(11'h120, word);
    check_value("chan0 after all writes", exp_cfg[0], dac_chan_cfg[0]);
    check_value("chan1 after all writes", exp_cfg[1], dac_chan_cfg[1]);

    // Reset release, sync pulse and format
    write_reg(11'h010, 32'h1);
    check_value("dac_rst released", 0, dac_rst);
    write_reg(11'h011, 32'h1);
    check_value("dac_sync pulse", 1, dac_sync);
    @(negedge up_clk);
    check_value("dac_sync after pulse", 0, dac_sync);
    read_check("sync control", 11'h011, 0);
    write_reg(11'h012, 32'h1);
    check_value("dac_dds_format", 1, dac_dds_format);
    read_check("format", 11'h012, 1);

    // Sticky underflow and sync input
    read_check("underflow idle", 11'h020, 0);
    @(negedge up_clk);
    dac_underflow = 1'b1;
    @(negedge up_clk);
    dac_underflow = 1'b0;
    read_check("underflow set", 11'h020, 1);
    read_check("underflow held", 11'h020, 1);
    write_reg(11'h020, 32'h1);
    read_check("underflow cleared", 11'h020, 0);
    dac_sync_in_status = 1'b1;
    read_check("sync input high", 11'h021, 1);
    dac_sync_in_status = 1'b0;
    read_check("sync input low", 11'h021, 0);

    repeat (2) @(negedge up_clk);
    total_errors = value_errors + timeout_errors + DUT.u_assertions.fail_count;
    $display("Errors: %0d value, %0d timeout, %0d assertion", value_errors, timeout_errors,
             DUT.u_assertions.fail_count);
    if (total_errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule
